//--- cache.f
logic/cache_params_pkg.sv
logic/cache_types.sv
logic/ff_array.sv
logic/cache_data_array.sv
logic/cache_control.sv
logic/cache_datapath.sv
logic/cache.sv
dv/line_memory_model.sv
dv/cache_tb.sv

//--- dv/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    import cache_params_pkg::*;
    import cache_types::*;

    localparam logic [31:0] fill_key = 32'hc0de_5a17;

    logic        clk;
    logic        reset;
    cpu_req_t    cpu_req;
    cpu_rsp_t    cpu_rsp;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    int          wb_count;
    logic [31:0] wb_addr;
    cache_line_u wb_line;

    int          errors;
    int          read_errors;
    logic        stalled;
    int          latency;
    logic        strobed;
    logic [31:0] rand_state;
    logic [31:0] shadow [logic [31:0]];

    // Reference tag state and tree bits
    logic                ref_valid [num_sets][num_ways];
    logic                ref_dirty [num_sets][num_ways];
    logic [tag_bits-1:0] ref_tag [num_sets][num_ways];
    logic [2:0]          ref_plru [num_sets];

    cache u_cache (
        .clk     (clk),
        .reset   (reset),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    line_memory_model #(.fill_key(fill_key)) u_memory (
        .clk      (clk),
        .reset    (reset),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .wb_count (wb_count),
        .wb_addr  (wb_addr),
        .wb_line  (wb_line)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [31:0] word_addr;
        word_addr = {addr[31:2], 2'b00};
        if (shadow.exists(word_addr)) begin
            return shadow[word_addr];
        end
        return word_addr ^ fill_key;
    endfunction

    function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] wdata,
                                               input logic [3:0] wmask);
        logic [31:0] word;
        word = old;
        for (int b = 0; b < 4; b++) begin
            if (wmask[b]) word[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return word;
    endfunction

    // Walks the reference tags, returns the write-back an access must cause
    task automatic predict_access(input logic [31:0] addr, input logic is_write,
                                  output logic wb_expected, output logic [31:0] wb_target);
        logic [index_bits-1:0] set_idx;
        logic [tag_bits-1:0]   tag;
        int                    way;
        set_idx     = addr[8:5];
        tag         = addr[31:9];
        way         = -1;
        wb_expected = 1'b0;
        wb_target   = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (ref_valid[set_idx][w] && ref_tag[set_idx][w] == tag) way = w;
        end
        if (way < 0) begin
            for (int w = num_ways - 1; w >= 0; w--) begin
                if (!ref_valid[set_idx][w]) way = w;
            end
            if (way < 0) begin
                if (ref_plru[set_idx][0]) way = ref_plru[set_idx][2] ? 3 : 2;
                else way = ref_plru[set_idx][1] ? 1 : 0;
            end
            wb_expected = ref_valid[set_idx][way] && ref_dirty[set_idx][way];
            wb_target   = {ref_tag[set_idx][way], set_idx, 5'b0};
            ref_valid[set_idx][way] = 1'b1;
            ref_dirty[set_idx][way] = 1'b0;
            ref_tag[set_idx][way]   = tag;
        end
        // Tree points away from the way just used
        if (way < 2) begin
            ref_plru[set_idx][0] = 1'b1;
            ref_plru[set_idx][1] = (way == 0);
        end else begin
            ref_plru[set_idx][0] = 1'b0;
            ref_plru[set_idx][2] = (way == 2);
        end
        if (is_write) ref_dirty[set_idx][way] = 1'b1;
    endtask

    task automatic access(input logic [31:0] addr, input logic is_write,
                          input logic [3:0] wmask, input logic [31:0] wdata);
        logic        wb_expected;
        logic [31:0] wb_target;
        int          wb_before;
        if (stalled) return;
        predict_access(addr, is_write, wb_expected, wb_target);
        wb_before = wb_count;
        @(negedge clk);
        cpu_req.addr  = addr;
        cpu_req.rmask = !is_write;
        cpu_req.wmask = is_write ? wmask : 4'h0;
        cpu_req.wdata = wdata;
        latency = 1;
        strobed = 1'b0;
        do begin
            @(negedge clk);
            latency = latency + 1;
            if (mem_req.read || mem_req.write) strobed = 1'b1;
        end while (!cpu_rsp.resp && latency < 200);
        if (!cpu_rsp.resp) begin
            $display("cache gave no response within 200 cycles for address %h", addr);
            errors  = errors + 1;
            stalled = 1'b1;
            return;
        end
        if (wb_count - wb_before != int'(wb_expected)) begin
            $display("CHECK FAILED write-back count at %h: expected %h got %h",
                     addr, wb_expected, wb_count - wb_before);
            errors = errors + 1;
        end else if (wb_expected) begin
            if (wb_addr != wb_target) begin
                $display("CHECK FAILED mem_req.addr: expected %h got %h", wb_target, wb_addr);
                errors = errors + 1;
            end
            for (int w = 0; w < words_per_line; w++) begin
                if (wb_line.words[w] != ref_read(wb_target + 32'(w * 4))) begin
                    $display("CHECK FAILED mem_req.wdata word %0d: expected %h got %h",
                             w, ref_read(wb_target + 32'(w * 4)), wb_line.words[w]);
                    errors = errors + 1;
                end
            end
        end
        if (is_write) shadow[{addr[31:2], 2'b00}] = merge_word(ref_read(addr), wdata, wmask);
        @(negedge clk);
        cpu_req = '0;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Every read response against the shadow memory
    always @(negedge clk) begin
        if (!reset && cpu_rsp.resp && cpu_req.rmask) begin
            if (cpu_rsp.rdata != ref_read(cpu_req.addr)) begin
                $display("CHECK FAILED cpu_rsp.rdata at %h: expected %h got %h",
                         cpu_req.addr, ref_read(cpu_req.addr), cpu_rsp.rdata);
                read_errors = read_errors + 1;
            end
        end
    end

    initial begin
        logic [31:0] addr;
        logic [3:0]  mask;
        logic        wr;
        int          wb_seen;
        errors      = 0;
        read_errors = 0;
        stalled     = 1'b0;
        rand_state  = 32'h7066ea06;
        reset       = 1'b1;
        cpu_req     = '0;
        for (int s = 0; s < num_sets; s++) begin
            ref_plru[s] = 3'b000;
            for (int w = 0; w < num_ways; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if ({cpu_rsp.resp, mem_req.read, mem_req.write} != 3'b000) begin
            $display("CHECK FAILED {cpu_rsp.resp, mem_req.read, mem_req.write}: expected 0 got %h",
                     {cpu_rsp.resp, mem_req.read, mem_req.write});
            errors = errors + 1;
        end

        // Miss then hit on the same line
        access(32'h0000_1044, 1'b0, 4'h0, 32'h0);
        access(32'h0000_1044, 1'b0, 4'h0, 32'h0);
        if (latency != 2 || strobed) begin
            $display("CHECK FAILED hit latency, mem strobe: expected 2, 0 got %h, %h",
                     latency, strobed);
            errors = errors + 1;
        end

        for (int m = 1; m < 16; m++) begin
            rand_state = lcg_next(rand_state);
            access(32'h0000_2088, 1'b1, 4'(m), rand_state);
            access(32'h0000_2088, 1'b0, 4'h0, 32'h0);
        end

        // Fill set 6 dirty, touch way 0, the fifth tag then evicts way 2
        for (int t = 0; t < 4; t++) begin
            rand_state = lcg_next(rand_state);
            access({23'(9'h100 + t), 4'd6, 5'd4}, 1'b1, 4'hf, rand_state);
        end
        access({23'h100, 4'd6, 5'd4}, 1'b0, 4'h0, 32'h0);
        wb_seen = wb_count;
        access({23'h104, 4'd6, 5'd0}, 1'b0, 4'h0, 32'h0);
        if (wb_count != wb_seen + 1 || wb_addr != {23'h102, 4'd6, 5'd0}) begin
            $display("CHECK FAILED victim write-back: expected %h got %h", {23'h102, 4'd6, 5'd0},
                     wb_addr);
            errors = errors + 1;
        end

        for (int n = 0; n < 300; n++) begin
            rand_state = lcg_next(rand_state);
            addr = {20'h00040, rand_state[30:28], 2'b00, 2'(rand_state[27:26] % 2'd3),
                    rand_state[25:23], 2'b00};
            mask = rand_state[21:18];
            if (mask == 4'h0) mask = 4'hf;
            wr = rand_state[22];
            rand_state = lcg_next(rand_state);
            access(addr, wr, mask, rand_state);
        end
        foreach (shadow[a]) begin
            access(a, 1'b0, 4'h0, 32'h0);
        end

        $display("errors: %0d, read mismatches: %0d", errors, read_errors);
        if (errors == 0 && read_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- dv/line_memory_model.sv
`timescale 1ns/1ps

module line_memory_model #(
    parameter logic [31:0] fill_key = 32'h0
) (
    input  logic                     clk,
    input  logic                     reset,
    input  cache_types::mem_req_t    mem_req,
    output cache_types::mem_rsp_t    mem_rsp,
    output int                       wb_count,
    output logic [31:0]              wb_addr,
    output cache_types::cache_line_u wb_line
);

    import cache_params_pkg::*;
    import cache_types::*;

    cache_line_u lines [logic [31:0]];
    logic [31:0] seed;
    logic        busy;
    int          wait_left;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Untouched lines hold address XOR key in every word
    function automatic cache_line_u fetch_line(input logic [31:0] addr);
        cache_line_u line;
        if (lines.exists(addr)) begin
            return lines[addr];
        end
        for (int w = 0; w < words_per_line; w++) begin
            line.words[w] = (addr + 32'(w * 4)) ^ fill_key;
        end
        return line;
    endfunction

    initial begin
        seed      = 32'h7066ea06;
        busy      = 1'b0;
        wait_left = 0;
        mem_rsp   = '0;
        wb_count  = 0;
        wb_addr   = '0;
        wb_line   = '0;
        forever begin
            @(negedge clk);
            if (reset || mem_rsp.resp) begin
                // A strobe seen after resp belongs to the next request
                busy         = 1'b0;
                mem_rsp.resp = 1'b0;
            end else if (mem_req.read || mem_req.write) begin
                if (!busy) begin
                    seed      = lcg_step(seed);
                    wait_left = 1 + int'(seed[23:16] % 8'd6);
                    busy      = 1'b1;
                end
                wait_left = wait_left - 1;
                if (wait_left == 0) begin
                    if (mem_req.write) begin
                        lines[mem_req.addr] = mem_req.wdata;
                        wb_count = wb_count + 1;
                        wb_addr  = mem_req.addr;
                        wb_line  = mem_req.wdata;
                        $display("write-back to line %h", mem_req.addr);
                    end else begin
                        mem_rsp.rdata = fetch_line(mem_req.addr);
                    end
                    mem_rsp.resp = 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/cache.sv
`timescale 1ns/1ps

module cache (
    input  logic                  clk,
    input  logic                  reset,
    input  cache_types::cpu_req_t cpu_req,
    output cache_types::cpu_rsp_t cpu_rsp,
    output cache_types::mem_req_t mem_req,
    input  cache_types::mem_rsp_t mem_rsp
);

    import cache_params_pkg::*;
    import cache_types::*;

    state_t                 state;
    logic                   hit;
    logic                   dirty_victim;
    logic                   mem_read;
    logic                   mem_write;
    logic [index_bits-1:0]  index;
    logic [tag_bits-1:0]    victim_tag;
    way_status_t            way_status [num_ways];
    cache_line_u            way_lines [num_ways];
    logic                   valid_we [num_ways];
    logic                   tag_we [num_ways];
    logic                   data_we [num_ways];
    tag_entry_t             tag_din;
    cache_line_u            data_din;
    cache_line_u            wb_line;
    logic [line_bytes-1:0]  data_mask;
    logic                   plru_we;
    logic [plru_width-1:0]  plru_bits;
    logic [plru_width-1:0]  plru_din;

    assign index = cpu_req.addr[offset_bits +: index_bits];

    cache_control u_control (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .hit          (hit),
        .dirty_victim (dirty_victim),
        .mem_rsp_resp (mem_rsp.resp),
        .state        (state),
        .mem_read     (mem_read),
        .mem_write    (mem_write)
    );

    cache_datapath u_datapath (
        .clk          (clk),
        .reset        (reset),
        .state        (state),
        .cpu_req      (cpu_req),
        .way_status   (way_status),
        .way_lines    (way_lines),
        .plru_bits    (plru_bits),
        .mem_line     (mem_rsp.rdata),
        .mem_rsp_resp (mem_rsp.resp),
        .cpu_rsp      (cpu_rsp),
        .hit          (hit),
        .dirty_victim (dirty_victim),
        .victim_tag   (victim_tag),
        .wb_line      (wb_line),
        .valid_we     (valid_we),
        .tag_we       (tag_we),
        .data_we      (data_we),
        .tag_din      (tag_din),
        .data_din     (data_din),
        .data_mask    (data_mask),
        .plru_we      (plru_we),
        .plru_din     (plru_din)
    );

    ff_array #(.width(plru_width), .depth(num_sets)) u_plru_array (
        .clk   (clk),
        .reset (reset),
        .we    (plru_we),
        .addr  (index),
        .din   (plru_din),
        .dout  (plru_bits)
    );

    for (genvar i = 0; i < num_ways; i++) begin : g_way
        logic       way_valid;
        tag_entry_t way_tag;

        cache_data_array u_data_array (
            .clk       (clk),
            .we        (data_we[i]),
            .byte_mask (data_mask),
            .addr      (index),
            .din       (data_din),
            .dout      (way_lines[i])
        );

        // Valid only ever gets set
        ff_array #(.width(1), .depth(num_sets)) u_valid_array (
            .clk   (clk),
            .reset (reset),
            .we    (valid_we[i]),
            .addr  (index),
            .din   (1'b1),
            .dout  (way_valid)
        );

        ff_array #(.width(tag_entry_bits), .depth(num_sets)) u_tag_array (
            .clk   (clk),
            .reset (reset),
            .we    (tag_we[i]),
            .addr  (index),
            .din   (tag_din),
            .dout  (way_tag)
        );

        assign way_status[i] = {way_valid, way_tag};
    end

    always_comb begin
        case (state)
            writeback_s: mem_req.addr = {victim_tag, index, offset_bits'(0)};
            default:     mem_req.addr = {cpu_req.addr[addr_bits-1:offset_bits], offset_bits'(0)};
        endcase
        mem_req.read  = mem_read;
        mem_req.write = mem_write;
        mem_req.wdata = wb_line;
    end

endmodule

//--- logic/cache_control.sv
`timescale 1ns/1ps

module cache_control (
    input  logic                  clk,
    input  logic                  reset,
    input  cache_types::cpu_req_t cpu_req,
    input  logic                  hit,
    input  logic                  dirty_victim,
    input  logic                  mem_rsp_resp,
    output cache_types::state_t   state,
    output logic                  mem_read,
    output logic                  mem_write
);

    import cache_types::*;

    state_t next_state;
    logic   req_valid;

    assign req_valid = cpu_req.rmask || (|cpu_req.wmask);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle_s;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle_s: begin
                if (req_valid) begin
                    next_state = compare_tag_s;
                end
            end
            compare_tag_s: begin
                // Datapath responds in this cycle on a hit
                if (hit) begin
                    next_state = idle_s;
                end else if (dirty_victim) begin
                    next_state = writeback_s;
                end else begin
                    next_state = allocate_s;
                end
            end
            writeback_s: begin
                if (mem_rsp_resp) begin
                    next_state = allocate_s;
                end
            end
            allocate_s: begin
                if (mem_rsp_resp) begin
                    next_state = refill_wait_s;
                end
            end
            // Arrays need one more read before the refilled line is visible
            refill_wait_s: next_state = compare_tag_s;
            default: next_state = idle_s;
        endcase
    end

    assign mem_read  = state == allocate_s;
    assign mem_write = state == writeback_s;

    mem_strobe_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write));

    state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {idle_s, compare_tag_s, writeback_s, allocate_s, refill_wait_s});

endmodule

//--- logic/cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array (
    input  logic                                   clk,
    input  logic                                   we,
    input  logic [cache_params_pkg::line_bytes-1:0] byte_mask,
    input  logic [cache_params_pkg::index_bits-1:0] addr,
    input  cache_types::cache_line_u               din,
    output cache_types::cache_line_u               dout
);

    import cache_params_pkg::*;

    logic [line_bytes-1:0][7:0] lines [num_sets];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < line_bytes; b++) begin
                if (byte_mask[b]) begin
                    lines[addr][b] <= din.flat[b*8 +: 8];
                end
            end
        end
        dout.flat <= lines[addr];
    end

endmodule

//--- logic/cache_datapath.sv
`timescale 1ns/1ps

module cache_datapath (
    input  logic                                    clk,
    input  logic                                    reset,
    input  cache_types::state_t                     state,
    input  cache_types::cpu_req_t                   cpu_req,
    input  cache_types::way_status_t                way_status [cache_params_pkg::num_ways],
    input  cache_types::cache_line_u                way_lines [cache_params_pkg::num_ways],
    input  logic [cache_params_pkg::plru_width-1:0] plru_bits,
    input  cache_types::cache_line_u                mem_line,
    input  logic                                    mem_rsp_resp,
    output cache_types::cpu_rsp_t                   cpu_rsp,
    output logic                                    hit,
    output logic                                    dirty_victim,
    output logic [cache_params_pkg::tag_bits-1:0]   victim_tag,
    output cache_types::cache_line_u                wb_line,
    output logic                                    valid_we [cache_params_pkg::num_ways],
    output logic                                    tag_we [cache_params_pkg::num_ways],
    output logic                                    data_we [cache_params_pkg::num_ways],
    output cache_types::tag_entry_t                 tag_din,
    output cache_types::cache_line_u                data_din,
    output logic [cache_params_pkg::line_bytes-1:0] data_mask,
    output logic                                    plru_we,
    output logic [cache_params_pkg::plru_width-1:0] plru_din
);

    import cache_params_pkg::*;
    import cache_types::*;

    logic [tag_bits-1:0]      req_tag;
    logic [word_sel_bits-1:0] word_sel;
    logic [num_ways-1:0]      way_hit;
    logic [way_bits-1:0]      hit_way;
    logic [way_bits-1:0]      victim_way;
    logic                     all_valid;
    logic                     write_hit;
    logic                     refill;
    cache_line_u              hit_line;

    assign req_tag  = cpu_req.addr[addr_bits-1 -: tag_bits];
    assign word_sel = cpu_req.addr[offset_bits-1 -: word_sel_bits];

    always_comb begin
        way_hit = '0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = way_status[w].valid && (way_status[w].tag_entry.tag == req_tag);
            if (way_hit[w]) begin
                hit_way = way_bits'(w);
            end
        end
    end

    assign hit      = |way_hit;
    assign hit_line = way_lines[hit_way];

    assign cpu_rsp.resp  = (state == compare_tag_s) && hit;
    assign cpu_rsp.rdata = hit_line.words[word_sel];

    // Lowest invalid way first, tree otherwise
    always_comb begin
        all_valid  = 1'b1;
        victim_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!way_status[w].valid) begin
                all_valid  = 1'b0;
                victim_way = way_bits'(w);
            end
        end
        if (all_valid) begin
            if (!plru_bits[0]) begin
                victim_way = {1'b0, plru_bits[1]};
            end else begin
                victim_way = {1'b1, plru_bits[2]};
            end
        end
    end

    assign dirty_victim = way_status[victim_way].valid && way_status[victim_way].tag_entry.dirty;
    assign victim_tag   = way_status[victim_way].tag_entry.tag;
    assign wb_line      = way_lines[victim_way];

    // Point every node on the path away from the hit way
    always_comb begin
        plru_din    = plru_bits;
        plru_din[0] = ~hit_way[1];
        if (hit_way[1]) begin
            plru_din[2] = ~hit_way[0];
        end else begin
            plru_din[1] = ~hit_way[0];
        end
    end

    assign plru_we = (state == compare_tag_s) && hit;

    assign write_hit = (state == compare_tag_s) && hit && (|cpu_req.wmask);
    assign refill    = (state == allocate_s) && mem_rsp_resp;

    always_comb begin
        data_din                 = hit_line;
        data_din.words[word_sel] = cpu_req.wdata;
        data_mask                = line_bytes'(cpu_req.wmask) << {word_sel, 2'b00};
        tag_din.dirty            = 1'b1;
        tag_din.tag              = req_tag;
        for (int w = 0; w < num_ways; w++) begin
            valid_we[w] = 1'b0;
            tag_we[w]   = write_hit && way_hit[w];
            data_we[w]  = write_hit && way_hit[w];
        end
        // Fresh line from memory goes in clean
        if (refill) begin
            data_din      = mem_line;
            data_mask     = '1;
            tag_din.dirty = 1'b0;
            for (int w = 0; w < num_ways; w++) begin
                valid_we[w] = victim_way == way_bits'(w);
                tag_we[w]   = victim_way == way_bits'(w);
                data_we[w]  = victim_way == way_bits'(w);
            end
        end
    end

    hit_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(way_hit));

endmodule

//--- logic/cache_params_pkg.sv
package cache_params_pkg;

    // Byte addresses, 32-bit CPU words
    localparam int addr_bits = 32;
    localparam int word_bits = 32;

    // Associativity
    localparam int num_ways = 4;
    localparam int way_bits = $clog2(num_ways);

    // Sets and address split
    localparam int num_sets    = 16;
    localparam int index_bits  = 4;
    localparam int offset_bits = 5;
    localparam int tag_bits    = addr_bits - index_bits - offset_bits;

    // Line shape
    localparam int line_bits      = 256;
    localparam int line_bytes     = line_bits / 8;
    localparam int words_per_line = line_bits / word_bits;
    localparam int word_sel_bits  = $clog2(words_per_line);

    // Dirty bit sits above the tag
    localparam int tag_entry_bits = tag_bits + 1;

    // Tree pseudo-LRU, one bit per internal node
    localparam int plru_width = num_ways - 1;

endpackage

//--- logic/cache_types.sv
package cache_types;

    import cache_params_pkg::*;

    typedef enum logic [2:0] {
        idle_s        = 3'd0,
        compare_tag_s = 3'd1,
        writeback_s   = 3'd2,
        allocate_s    = 3'd3,
        refill_wait_s = 3'd4
    } state_t;

    // Same bits seen by memory as a line and by the CPU as words
    typedef union packed {
        logic [line_bits-1:0]                      flat;
        logic [words_per_line-1:0][word_bits-1:0] words;
    } cache_line_u;

    typedef struct packed {
        logic [addr_bits-1:0] addr;
        logic                 rmask;
        logic [3:0]           wmask;
        logic [word_bits-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                 resp;
        logic [word_bits-1:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic [addr_bits-1:0] addr;
        logic                 read;
        logic                 write;
        cache_line_u          wdata;
    } mem_req_t;

    typedef struct packed {
        logic        resp;
        cache_line_u rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                dirty;
        logic [tag_bits-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic       valid;
        tag_entry_t tag_entry;
    } way_status_t;

endpackage

//--- logic/ff_array.sv
`timescale 1ns/1ps

module ff_array #(
    parameter int width = 1,
    parameter int depth = cache_params_pkg::num_sets
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic [width-1:0]         din,
    output logic [width-1:0]         dout
);

    logic [width-1:0] entries [depth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                entries[i] <= '0;
            end
            dout <= '0;
        end else begin
            if (we) begin
                entries[addr] <= din;
            end
            // Read sees the value from before this edge's write
            dout <= entries[addr];
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f cache.f --top-module cache_tb -o cache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
    exit 0
fi
exit 1
